/* hdl/snd_bus_pkg.sv */
/*
 * host port map of the sound block
 * port offsets, mixer register indices, DSP command codes
 */
package snd_bus_pkg;

	// offsets inside the 220h-22Fh window
	localparam logic [3:0] io_tone_data  = 4'h0; // tone chip data
	localparam logic [3:0] io_tone_addr  = 4'h1; // tone chip register select
	localparam logic [3:0] io_mix_index  = 4'h4;
	localparam logic [3:0] io_mix_data   = 4'h5;
	localparam logic [3:0] io_dsp_reset  = 4'h6; // 1 then 0 resets the DSP
	localparam logic [3:0] io_dsp_read   = 4'hA; // output byte
	localparam logic [3:0] io_dsp_write  = 4'hC; // command and data in
	localparam logic [3:0] io_dsp_status = 4'hE; // bit 7 means data waiting

	// mixer register indices
	localparam logic [7:0] mix_reset      = 8'h00;
	localparam logic [7:0] mix_vol_pair   = 8'h22; // master, nibble per side
	localparam logic [7:0] mix_vol_l      = 8'h30;
	localparam logic [7:0] mix_vol_r      = 8'h31;
	localparam logic [7:0] mix_irq_cfg    = 8'h80;
	localparam logic [7:0] mix_dma_cfg    = 8'h81;
	localparam logic [7:0] mix_irq_status = 8'h82;

	// DSP commands
	localparam logic [7:0] dsp_cmd_direct  = 8'h10; // next byte goes to the DAC
	localparam logic [7:0] dsp_cmd_irq     = 8'hF2; // raise the 8-bit irq
	localparam logic [7:0] dsp_cmd_version = 8'hE1;

	localparam logic [7:0] dsp_ready_byte = 8'hAA; // answer to a DSP reset

endpackage

/* hdl/snd_audio_pkg.sv */
/*
 * audio sample widths, tone chip register indices
 * and the two views of a tone data byte
 */
package snd_audio_pkg;

	localparam int sample_w = 16; // signed pcm sample
	localparam int tone_w   = 8;  // unsigned tone sum per side

	// tone chip register indices
	localparam logic [2:0] tone_amp0   = 3'd0;
	localparam logic [2:0] tone_freq0  = 3'd1;
	localparam logic [2:0] tone_amp1   = 3'd2;
	localparam logic [2:0] tone_freq1  = 3'd3;
	localparam logic [2:0] tone_enable = 3'd4; // bit n enables channel n

	// one data byte, read as amplitudes or as a divider
	typedef union packed {
		struct packed {
			logic [3:0] right; // upper nibble
			logic [3:0] left;
		} amp;
		logic [7:0] freq; // half period in ce ticks, minus one
	} tone_data_t;

endpackage

/* hdl/rate_ce_gen.sv */
/*
 * fractional rate clock enable
 * one ce pulse per clk_hz/out_hz cycles on average
 */
module rate_ce_gen #(
	parameter logic [27:0] clk_hz = 28'd50_000_000,
	parameter logic [27:0] out_hz = 28'd1_000_000
) (
	input  logic clk,
	input  logic rst_n,
	output logic ce
);

	logic [27:0] acc;     // phase, always below clk_hz
	logic [27:0] acc_sum;

	assign acc_sum = acc + out_hz; // no wrap while clk_hz stays under 2^27

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			acc <= '0;
			ce  <= 1'b0;
		end else if (acc_sum >= clk_hz) begin
			acc <= acc_sum - clk_hz; // keep the remainder
			ce  <= 1'b1;
		end else begin
			acc <= acc_sum;
			ce  <= 1'b0;
		end
	end

endmodule

/* hdl/tone_chip.sv */
/*
 * two channel square wave tone chip
 * index/data register file, divider counters, stereo amplitude sum
 */
module tone_chip (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             ce,
	input  logic                             wr,
	input  logic                             a0,
	input  logic [7:0]                       wdata,
	output logic [snd_audio_pkg::tone_w-1:0] tone_l,
	output logic [snd_audio_pkg::tone_w-1:0] tone_r
);
	import snd_audio_pkg::*;

	tone_data_t        wd;
	logic [2:0]        idx;       // selected register
	logic [1:0]        en;        // channel enables
	logic [3:0]        amp_l [2];
	logic [3:0]        amp_r [2];
	logic [7:0]        freq [2];
	logic [7:0]        cnt [2];   // divider counters
	logic              sq [2];    // square outputs
	logic [tone_w-1:0] sum_l;
	logic [tone_w-1:0] sum_r;

	assign wd = wdata;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			idx <= '0;
			en  <= '0; // silent until enabled
		end else if (wr) begin
			if (a0)
				idx <= wdata[2:0];
			else if (idx == tone_enable)
				en <= wdata[1:0];
		end
	end

	// amplitude and divider registers
	always_ff @(posedge clk) begin
		if (wr && !a0) begin
			case (idx)
				tone_amp0: begin
					amp_l[0] <= wd.amp.left;
					amp_r[0] <= wd.amp.right;
				end
				tone_amp1: begin
					amp_l[1] <= wd.amp.left;
					amp_r[1] <= wd.amp.right;
				end
				tone_freq0: freq[0] <= wd.freq;
				tone_freq1: freq[1] <= wd.freq;
				default: ;
			endcase
		end
	end

	for (genvar ch = 0; ch < 2; ch++) begin : g_chan
		always_ff @(posedge clk) begin
			if (!rst_n) begin
				cnt[ch] <= '0;
				sq[ch]  <= 1'b0;
			end else if (ce) begin
				if (cnt[ch] == freq[ch]) begin // freq+1 ticks per half period
					cnt[ch] <= '0;
					sq[ch]  <= ~sq[ch];
				end else begin
					cnt[ch] <= cnt[ch] + 8'd1;
				end
			end
		end
	end

	// amplitude times 8 per active channel, 240 max
	always_comb begin
		sum_l = '0;
		sum_r = '0;
		for (int ch = 0; ch < 2; ch++) begin
			if (en[ch] && sq[ch]) begin
				sum_l = sum_l + {1'b0, amp_l[ch], 3'b000};
				sum_r = sum_r + {1'b0, amp_r[ch], 3'b000};
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			tone_l <= '0;
			tone_r <= '0;
		end else if (ce) begin // outputs move on the tone tick only
			tone_l <= sum_l;
			tone_r <= sum_r;
		end
	end

endmodule

/* hdl/dsp_dac.sv */
/*
 * 8-bit DSP: reset handshake, command decoder,
 * one entry output FIFO, direct DAC sample and test irq
 */
module dsp_dac (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic                               wr,
	input  logic                               rd,
	input  logic [3:0]                         address,
	input  logic [7:0]                         wdata,
	output logic [7:0]                         rdata,
	output logic                               irq8,
	output logic [snd_audio_pkg::sample_w-1:0] sample_l,
	output logic [snd_audio_pkg::sample_w-1:0] sample_r
);
	import snd_bus_pkg::*;

	localparam logic [7:0] ver_major = 8'h04;
	localparam logic [7:0] ver_minor = 8'h05;

	logic       rst_arm;   // 1 seen on the reset port
	logic       want_data; // byte after 10h is a sample
	logic       out_valid; // output FIFO full
	logic       ver_pend;  // minor version still to come
	logic [7:0] out_data;
	logic       cmd_wr;
	logic       data_wr;
	logic       rst_load;
	logic       pop;

	assign cmd_wr   = wr && address == io_dsp_write && !want_data;
	assign data_wr  = wr && address == io_dsp_write && want_data;
	assign rst_load = wr && address == io_dsp_reset && rst_arm && !wdata[0]; // falling edge
	assign pop      = rd && address == io_dsp_read && out_valid;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rst_arm   <= 1'b0;
			want_data <= 1'b0;
			out_valid <= 1'b0;
			ver_pend  <= 1'b0;
			irq8      <= 1'b0;
		end else begin
			if (wr && address == io_dsp_reset)
				rst_arm <= wdata[0];
			if (rst_load) begin // ready byte, drop any command in progress
				want_data <= 1'b0;
				out_valid <= 1'b1;
				ver_pend  <= 1'b0;
			end
			if (data_wr)
				want_data <= 1'b0;
			if (cmd_wr) begin
				case (wdata)
					dsp_cmd_direct: want_data <= 1'b1;
					dsp_cmd_irq:    irq8 <= 1'b1;
					dsp_cmd_version: begin
						out_valid <= 1'b1;
						ver_pend  <= 1'b1;
					end
					default: ; // unknown commands ignored
				endcase
			end
			if (pop) begin
				out_valid <= ver_pend; // refill with the minor version
				ver_pend  <= 1'b0;
			end
			if (rd && address == io_dsp_status)
				irq8 <= 1'b0; // status read acks the irq
		end
	end

	always_ff @(posedge clk) begin
		if (rst_load)
			out_data <= dsp_ready_byte;
		else if (cmd_wr && wdata == dsp_cmd_version)
			out_data <= ver_major;
		else if (pop && ver_pend)
			out_data <= ver_minor;
	end

	// unsigned byte to signed, top bit flipped, into the high byte
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sample_l <= '0;
			sample_r <= '0;
		end else if (data_wr) begin
			sample_l <= {~wdata[7], wdata[6:0], 8'h00};
			sample_r <= {~wdata[7], wdata[6:0], 8'h00}; // mono dac, same both sides
		end
	end

	always_comb begin
		case (address)
			io_dsp_read:   rdata = out_data;
			io_dsp_status: rdata = {out_valid, 7'h7F};
			default:       rdata = 8'h00; // write port always ready
		endcase
	end

endmodule

/* hdl/mixer_regs.sv */
/*
 * mixer chip: index and data registers,
 * master volume per side and registered readback
 */
module mixer_regs (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       wr,
	input  logic       rd,
	input  logic [3:0] address,
	input  logic [7:0] wdata,
	input  logic       irq8,
	output logic [7:0] rdata,
	output logic [4:0] vol_l,
	output logic [4:0] vol_r
);
	import snd_bus_pkg::*;

	logic [7:0] idx;
	logic [7:0] idx_n;
	logic [4:0] vol_l_n;
	logic [4:0] vol_r_n;
	logic [7:0] mix_val; // readback for the current index

	always_comb begin
		idx_n   = idx;
		vol_l_n = vol_l;
		vol_r_n = vol_r;
		if (wr && address == io_mix_index)
			idx_n = wdata;
		if (wr && address == io_mix_data) begin
			case (idx)
				mix_reset: begin
					vol_l_n = 5'h1F; // full volume
					vol_r_n = 5'h1F;
				end
				mix_vol_pair: begin // 4-bit value, msb copied into bit 0
					vol_l_n = {wdata[7:4], wdata[7]};
					vol_r_n = {wdata[3:0], wdata[3]};
				end
				mix_vol_l: vol_l_n = wdata[7:3];
				mix_vol_r: vol_r_n = wdata[7:3];
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			idx   <= '0;
			vol_l <= 5'h1F;
			vol_r <= 5'h1F;
		end else begin
			idx   <= idx_n;
			vol_l <= vol_l_n;
			vol_r <= vol_r_n;
		end
	end

	// built from next state, so a read right after a write sees it
	always_ff @(posedge clk) begin
		case (idx_n)
			mix_vol_pair:   mix_val <= {vol_l_n[4:1], vol_r_n[4:1]};
			mix_vol_l:      mix_val <= {vol_l_n, 3'b000};
			mix_vol_r:      mix_val <= {vol_r_n, 3'b000};
			mix_irq_cfg:    mix_val <= 8'h02; // irq 5
			mix_dma_cfg:    mix_val <= 8'h22; // dma 1 and 5
			mix_irq_status: mix_val <= {7'd0, irq8};
			default:        mix_val <= 8'h00;
		endcase
	end

	// index port reads back the index, zero outside a read
	assign rdata = !rd ? 8'h00 : (address == io_mix_index) ? idx : mix_val;

endmodule

/* hdl/sample_mix.sv */
/*
 * output mixer: DSP plus tone sum,
 * then master volume as an arithmetic shift per side
 */
module sample_mix (
	input  logic                               clk,
	input  logic [snd_audio_pkg::sample_w-1:0] dsp_l,
	input  logic [snd_audio_pkg::sample_w-1:0] dsp_r,
	input  logic [snd_audio_pkg::tone_w-1:0]   tone_l,
	input  logic [snd_audio_pkg::tone_w-1:0]   tone_r,
	input  logic [4:0]                         vol_l,
	input  logic [4:0]                         vol_r,
	output logic [snd_audio_pkg::sample_w-1:0] sample_l,
	output logic [snd_audio_pkg::sample_w-1:0] sample_r
);
	import snd_audio_pkg::*;

	localparam int pad_w = sample_w - tone_w - 5; // zero fill above the tone

	logic signed [sample_w-1:0] pre_l;
	logic signed [sample_w-1:0] pre_r;

	// stage 1: dsp at quarter scale, tone up by 32, 15808 at most
	always_ff @(posedge clk) begin
		pre_l <= ($signed(dsp_l) >>> 2) + $signed({{pad_w{1'b0}}, tone_l, 5'b00000});
		pre_r <= ($signed(dsp_r) >>> 2) + $signed({{pad_w{1'b0}}, tone_r, 5'b00000});
	end

	// stage 2: vol 1Fh passes, each step down halves
	always_ff @(posedge clk) begin
		sample_l <= pre_l >>> (4'd15 - vol_l[4:1]);
		sample_r <= pre_r >>> (4'd15 - vol_r[4:1]); // right uses its own volume
	end

endmodule

/* hdl/sound_top.sv */
/*
 * sound card core: port decode, registered read mux,
 * tone tick, tone chip, DSP, mixer and output mix
 */
module sound_top #(
	parameter logic [27:0] clk_hz  = 28'd50_000_000,
	parameter logic [27:0] tone_hz = 28'd1_000_000
) (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic [3:0]                         address,
	input  logic                               read,
	input  logic                               write,
	input  logic [7:0]                         writedata,
	input  logic                               sb_cs,    // 220h-22Fh
	input  logic                               cms_en,   // tone chip present
	output logic [7:0]                         readdata,
	output logic                               irq,
	output logic [snd_audio_pkg::sample_w-1:0] sample_l,
	output logic [snd_audio_pkg::sample_w-1:0] sample_r
);
	import snd_bus_pkg::*;
	import snd_audio_pkg::*;

	logic                sb_rd;
	logic                sb_wr;
	logic                tone_sel;
	logic                mix_sel;
	logic                dsp_sel;
	logic                tone_wr;
	logic                mix_wr;
	logic                mix_rd;
	logic                dsp_wr;
	logic                dsp_rd;
	logic                ce_tone;
	logic [tone_w-1:0]   tone_l;
	logic [tone_w-1:0]   tone_r;
	logic [sample_w-1:0] dsp_sample_l;
	logic [sample_w-1:0] dsp_sample_r;
	logic [7:0]          dsp_rdata;
	logic [7:0]          mix_rdata;
	logic                irq8;
	logic [4:0]          vol_l;
	logic [4:0]          vol_r;

	assign sb_rd    = read && sb_cs;
	assign sb_wr    = write && sb_cs;
	assign tone_sel = cms_en && (address == io_tone_data || address == io_tone_addr);
	assign mix_sel  = address == io_mix_index || address == io_mix_data;
	assign dsp_sel  = address inside {io_dsp_reset, io_dsp_read, io_dsp_write, io_dsp_status};
	assign tone_wr  = sb_wr && tone_sel;
	assign mix_wr   = sb_wr && mix_sel;
	assign mix_rd   = sb_rd && mix_sel;
	assign dsp_wr   = sb_wr && dsp_sel;
	assign dsp_rd   = sb_rd && dsp_sel;
	assign irq      = irq8;

	// valid the cycle after read, tone chip has no readback
	always_ff @(posedge clk) begin
		if (mix_rd)
			readdata <= mix_rdata;
		else if (tone_sel)
			readdata <= 8'h7F;
		else
			readdata <= dsp_rdata; // 00h on unused offsets
	end

	rate_ce_gen #(
		.clk_hz (clk_hz),
		.out_hz (tone_hz)
	) i_tone_ce (
		.clk   (clk),
		.rst_n (rst_n),
		.ce    (ce_tone)
	);

	tone_chip i_tone (
		.clk    (clk),
		.rst_n  (rst_n && cms_en), // chip held in reset while disabled
		.ce     (ce_tone),
		.wr     (tone_wr),
		.a0     (address[0]),
		.wdata  (writedata),
		.tone_l (tone_l),
		.tone_r (tone_r)
	);

	dsp_dac i_dsp (
		.clk      (clk),
		.rst_n    (rst_n),
		.wr       (dsp_wr),
		.rd       (dsp_rd),
		.address  (address),
		.wdata    (writedata),
		.rdata    (dsp_rdata),
		.irq8     (irq8),
		.sample_l (dsp_sample_l),
		.sample_r (dsp_sample_r)
	);

	mixer_regs i_mixer (
		.clk     (clk),
		.rst_n   (rst_n),
		.wr      (mix_wr),
		.rd      (mix_rd),
		.address (address),
		.wdata   (writedata),
		.irq8    (irq8),
		.rdata   (mix_rdata),
		.vol_l   (vol_l),
		.vol_r   (vol_r)
	);

	sample_mix i_mix (
		.clk      (clk),
		.dsp_l    (dsp_sample_l),
		.dsp_r    (dsp_sample_r),
		.tone_l   (tone_l),
		.tone_r   (tone_r),
		.vol_l    (vol_l),
		.vol_r    (vol_r),
		.sample_l (sample_l),
		.sample_r (sample_r)
	);

endmodule

/* sim/tb_sound.sv */
/*
 * testbench for sound_top: clock, reset, stimulus table,
 * host bus tasks, sample settle checks and a tone window
 */
module tb_sound;
	timeunit 1ns;
	timeprecision 1ps;

	import snd_bus_pkg::*;
	import snd_audio_pkg::*;

	localparam int max_entries  = 96;
	localparam int settle_limit = 20;  // cycles for a sample to reach the output
	localparam int window_len   = 400; // tone observation window in cycles

	// table operations
	localparam logic [1:0] op_wr   = 2'd0;
	localparam logic [1:0] op_rd   = 2'd1; // read and compare under mask
	localparam logic [1:0] op_irq  = 2'd2; // compare the irq level
	localparam logic [1:0] op_samp = 2'd3; // wait for both samples

	logic                clk;
	logic                rst_n;
	logic [3:0]          address;
	logic                read;
	logic                write;
	logic [7:0]          writedata;
	logic                sb_cs;
	logic                cms_en;
	logic [7:0]          readdata;
	logic                irq;
	logic [sample_w-1:0] sample_l;
	logic [sample_w-1:0] sample_r;

	// stimulus table
	logic [1:0]  t_op [max_entries];
	logic [3:0]  t_addr [max_entries];
	logic [7:0]  t_data [max_entries];
	logic [15:0] t_exp [max_entries];   // read value, irq level or sample_l
	logic [15:0] t_exp_r [max_entries]; // sample_r
	logic [7:0]  t_mask [max_entries];
	int          t_test [max_entries];
	int          n_entries;
	int          cur_test;
	string       test_name [6];
	int          errors;
	int          checks;
	int          tests_run;

	sound_top #(
		.clk_hz  (28'd50_000_000),
		.tone_hz (28'd5_000_000) // ce every 10 cycles
	) i_dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.address   (address),
		.read      (read),
		.write     (write),
		.writedata (writedata),
		.sb_cs     (sb_cs),
		.cms_en    (cms_en),
		.readdata  (readdata),
		.irq       (irq),
		.sample_l  (sample_l),
		.sample_r  (sample_r)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk; // 50 MHz
	end

	// expected output from the mix rules: byte recentred and x256, then /4,
	// tone x32, then the volume shift
	function automatic logic [15:0] dac_level(input logic [7:0] dac_byte,
		input logic [7:0] tone, input logic [4:0] vol);
		int lvl;
		lvl = (int'(dac_byte) - 128) * 64 + int'(tone) * 32;
		lvl = lvl >>> (15 - int'(vol[4:1]));
		return 16'(lvl);
	endfunction

	task automatic add_entry(input logic [1:0] op, input logic [3:0] addr,
		input logic [7:0] data, input logic [15:0] exp_v, input logic [15:0] exp_r,
		input logic [7:0] mask);
		t_op[n_entries]    = op;
		t_addr[n_entries]  = addr;
		t_data[n_entries]  = data;
		t_exp[n_entries]   = exp_v;
		t_exp_r[n_entries] = exp_r;
		t_mask[n_entries]  = mask;
		t_test[n_entries]  = cur_test;
		n_entries++;
	endtask

	// called on a falling edge, returns on the next one
	task automatic bus_write(input logic [3:0] addr, input logic [7:0] data);
		address   = addr;
		writedata = data;
		write     = 1'b1;
		sb_cs     = 1'b1;
		@(negedge clk);
		write = 1'b0;
		sb_cs = 1'b0;
	endtask

	task automatic bus_read(input logic [3:0] addr, output logic [7:0] data);
		address = addr;
		read    = 1'b1;
		sb_cs   = 1'b1;
		@(negedge clk); // readdata registered at the edge in between
		read  = 1'b0;
		sb_cs = 1'b0;
		data  = readdata;
	endtask

	task automatic wait_samples(input logic [15:0] exp_l, input logic [15:0] exp_r);
		int n;
		n = 0;
		while ((sample_l !== exp_l || sample_r !== exp_r) && n < settle_limit) begin
			@(negedge clk);
			n++;
		end
		checks++;
		if (sample_l !== exp_l || sample_r !== exp_r)
			$display("samples did not settle within %0d cycles", settle_limit);
		if (sample_l !== exp_l) begin
			$display("Fail sample_l: got %h, expected %h", sample_l, exp_l);
			errors++;
		end
		if (sample_r !== exp_r) begin
			$display("Fail sample_r: got %h, expected %h", sample_r, exp_r);
			errors++;
		end
	endtask

	task automatic report_test(input int num, input int err_before);
		string verdict;
		verdict = (errors == err_before) ? "ok" : "failed";
		$display("test %0d %s: %s", num, test_name[num], verdict);
		tests_run++;
	endtask

	task automatic build_table;
		logic [7:0] vl;
		logic [7:0] vr;
		logic [7:0] pair;
		logic [7:0] b;
		int         k;
		cur_test = 1; // mixer registers
		vl   = 8'($urandom());
		vr   = 8'($urandom());
		pair = 8'($urandom());
		add_entry(op_wr, io_mix_index, mix_vol_l, 16'h0, 16'h0, 8'h00);
		add_entry(op_rd, io_mix_data, 8'h00, 16'h00F8, 16'h0, 8'hFF); // reset volume
		add_entry(op_wr, io_mix_data, vl, 16'h0, 16'h0, 8'h00);
		add_entry(op_rd, io_mix_data, 8'h00, {8'h00, vl[7:3], 3'b000}, 16'h0, 8'hFF);
		add_entry(op_wr, io_mix_index, mix_vol_r, 16'h0, 16'h0, 8'h00);
		add_entry(op_wr, io_mix_data, vr, 16'h0, 16'h0, 8'h00);
		add_entry(op_rd, io_mix_data, 8'h00, {8'h00, vr[7:3], 3'b000}, 16'h0, 8'hFF);
		add_entry(op_wr, io_mix_index, mix_vol_pair, 16'h0, 16'h0, 8'h00);
		add_entry(op_wr, io_mix_data, pair, 16'h0, 16'h0, 8'h00);
		add_entry(op_rd, io_mix_data, 8'h00, {8'h00, pair}, 16'h0, 8'hFF);
		// left nibble lands in 30h with its top bit copied down
		add_entry(op_wr, io_mix_index, mix_vol_l, 16'h0, 16'h0, 8'h00);
		add_entry(op_rd, io_mix_data, 8'h00, {8'h00, pair[7:4], pair[7], 3'b000}, 16'h0,
			8'hFF);
		add_entry(op_wr, io_mix_index, mix_reset, 16'h0, 16'h0, 8'h00);
		add_entry(op_wr, io_mix_data, 8'h00, 16'h0, 16'h0, 8'h00);
		add_entry(op_wr, io_mix_index, mix_vol_l, 16'h0, 16'h0, 8'h00);
		add_entry(op_rd, io_mix_data, 8'h00, 16'h00F8, 16'h0, 8'hFF);
		add_entry(op_wr, io_mix_index, mix_vol_r, 16'h0, 16'h0, 8'h00);
		add_entry(op_rd, io_mix_data, 8'h00, 16'h00F8, 16'h0, 8'hFF);
		add_entry(op_wr, io_mix_index, mix_irq_cfg, 16'h0, 16'h0, 8'h00);
		add_entry(op_rd, io_mix_data, 8'h00, 16'h0002, 16'h0, 8'hFF);
		add_entry(op_wr, io_mix_index, mix_dma_cfg, 16'h0, 16'h0, 8'h00);
		add_entry(op_rd, io_mix_data, 8'h00, 16'h0022, 16'h0, 8'hFF);

		cur_test = 2; // reset handshake, then version bytes
		add_entry(op_wr, io_dsp_reset, 8'h01, 16'h0, 16'h0, 8'h00);
		add_entry(op_wr, io_dsp_reset, 8'h00, 16'h0, 16'h0, 8'h00);
		add_entry(op_rd, io_dsp_status, 8'h00, 16'h0080, 16'h0, 8'h80); // data waiting
		add_entry(op_rd, io_dsp_read, 8'h00, 16'h00AA, 16'h0, 8'hFF);
		add_entry(op_rd, io_dsp_status, 8'h00, 16'h0000, 16'h0, 8'h80); // popped
		add_entry(op_wr, io_dsp_write, dsp_cmd_version, 16'h0, 16'h0, 8'h00);
		add_entry(op_rd, io_dsp_read, 8'h00, 16'h0004, 16'h0, 8'hFF);
		add_entry(op_rd, io_dsp_read, 8'h00, 16'h0005, 16'h0, 8'hFF);
		add_entry(op_rd, io_dsp_status, 8'h00, 16'h0000, 16'h0, 8'h80);

		cur_test = 3; // test interrupt and its ack
		add_entry(op_irq, 4'h0, 8'h00, 16'h0000, 16'h0, 8'h00);
		add_entry(op_wr, io_dsp_write, dsp_cmd_irq, 16'h0, 16'h0, 8'h00);
		add_entry(op_irq, 4'h0, 8'h00, 16'h0001, 16'h0, 8'h00);
		add_entry(op_wr, io_mix_index, mix_irq_status, 16'h0, 16'h0, 8'h00);
		add_entry(op_rd, io_mix_data, 8'h00, 16'h0001, 16'h0, 8'hFF);
		add_entry(op_rd, io_dsp_status, 8'h00, 16'h0000, 16'h0, 8'h80);
		add_entry(op_irq, 4'h0, 8'h00, 16'h0000, 16'h0, 8'h00);

		cur_test = 4; // direct dac at random volumes, tone chip off
		for (k = 0; k < 4; k++) begin
			vl = 8'($urandom());
			vr = 8'($urandom());
			b  = 8'($urandom());
			add_entry(op_wr, io_mix_index, mix_vol_l, 16'h0, 16'h0, 8'h00);
			add_entry(op_wr, io_mix_data, vl, 16'h0, 16'h0, 8'h00);
			add_entry(op_wr, io_mix_index, mix_vol_r, 16'h0, 16'h0, 8'h00);
			add_entry(op_wr, io_mix_data, vr, 16'h0, 16'h0, 8'h00);
			add_entry(op_wr, io_dsp_write, dsp_cmd_direct, 16'h0, 16'h0, 8'h00);
			add_entry(op_wr, io_dsp_write, b, 16'h0, 16'h0, 8'h00);
			add_entry(op_samp, 4'h0, 8'h00, dac_level(b, 8'h00, vl[7:3]),
				dac_level(b, 8'h00, vr[7:3]), 8'h00);
		end
	endtask

	task automatic apply_table;
		logic [7:0] rd;
		int         i;
		int         err_before;
		err_before = errors;
		for (i = 0; i < n_entries; i++) begin
			case (t_op[i])
				op_wr: bus_write(t_addr[i], t_data[i]);
				op_rd: begin
					bus_read(t_addr[i], rd);
					checks++;
					if ((rd & t_mask[i]) !== (t_exp[i][7:0] & t_mask[i])) begin
						$display("Fail readdata at offset %h: got %h, expected %h, mask %h",
							t_addr[i], rd, t_exp[i][7:0], t_mask[i]);
						errors++;
					end
				end
				op_irq: begin
					checks++;
					if (irq !== t_exp[i][0]) begin
						$display("Fail irq: got %h, expected %h", irq, t_exp[i][0]);
						errors++;
					end
				end
				op_samp: wait_samples(t_exp[i], t_exp_r[i]);
			endcase
			if (i == n_entries - 1 || t_test[i + 1] != t_test[i]) begin // last of its test
				report_test(t_test[i], err_before);
				err_before = errors;
			end
		end
	endtask

	task automatic tone_window;
		tone_data_t  td;
		logic [3:0]  amp;
		logic [15:0] level;
		logic [15:0] prev;
		int          toggles;
		int          bad;
		int          n;
		int          err_before;
		err_before = errors;
		amp = 4'($urandom_range(15, 1));
		cms_en = 1'b1; // tone chip out of reset
		@(negedge clk);
		bus_write(io_mix_index, mix_reset); // full volume
		bus_write(io_mix_data, 8'h00);
		bus_write(io_dsp_write, dsp_cmd_direct);
		bus_write(io_dsp_write, 8'h80); // dac at midscale, zero
		td = '0;
		td.amp.left = amp;
		bus_write(io_tone_addr, {5'd0, tone_amp0});
		bus_write(io_tone_data, td);
		td.freq = 8'($urandom_range(3, 0)); // short half period, many toggles
		bus_write(io_tone_addr, {5'd0, tone_freq0});
		bus_write(io_tone_data, td);
		bus_write(io_tone_addr, {5'd0, tone_enable});
		bus_write(io_tone_data, 8'h01);
		level = dac_level(8'h80, {1'b0, amp, 3'b000}, 5'h1F);
		prev = sample_l;
		toggles = 0;
		bad = 0;
		for (n = 0; n < window_len; n++) begin
			@(negedge clk);
			if (sample_l !== 16'h0000 && sample_l !== level) begin
				bad++;
				if (bad == 1)
					$display("Fail sample_l: got %h, expected 0000 or %h", sample_l, level);
			end
			if (sample_l !== prev)
				toggles++;
			prev = sample_l;
		end
		checks += 2;
		if (bad != 0)
			errors++;
		if (toggles == 0) begin
			$display("sample_l never toggled during the tone window");
			errors++;
		end
		// disable while the tone is high, so the drop to zero is visible
		n = 0;
		while (sample_l !== level && n < window_len) begin
			@(negedge clk);
			n++;
		end
		checks++;
		if (sample_l !== level) begin
			$display("sample_l never reached the tone level before disabling the chip");
			errors++;
		end
		cms_en = 1'b0; // silences the chip
		n = 0;
		while (sample_l !== 16'h0000 && n < settle_limit) begin
			@(negedge clk);
			n++;
		end
		checks++;
		bad = 0;
		for (n = 0; n < window_len / 4; n++) begin // longer than any half period
			if (sample_l !== 16'h0000 && bad == 0) begin
				$display("Fail sample_l: got %h, expected 0000", sample_l);
				bad++;
			end
			@(negedge clk);
		end
		if (bad != 0)
			errors++;
		report_test(5, err_before);
	endtask

	initial begin
		void'($urandom(15078));
		rst_n     = 1'b0;
		address   = 4'h0;
		read      = 1'b0;
		write     = 1'b0;
		writedata = 8'h00;
		sb_cs     = 1'b0;
		cms_en    = 1'b0; // tone chip off until test 5
		errors    = 0;
		checks    = 0;
		tests_run = 0;
		n_entries = 0;
		test_name[0] = "unused";
		test_name[1] = "mixer registers";
		test_name[2] = "DSP reset and version";
		test_name[3] = "interrupt";
		test_name[4] = "direct DAC through the mix";
		test_name[5] = "tone chip";
		build_table();
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		apply_table();
		tone_window();
		$display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

/* build.f */
hdl/snd_bus_pkg.sv
hdl/snd_audio_pkg.sv
hdl/rate_ce_gen.sv
hdl/tone_chip.sv
hdl/dsp_dac.sv
hdl/mixer_regs.sv
hdl/sample_mix.sv
hdl/sound_top.sv
sim/tb_sound.sv

/* run_sim.sh */
#!/bin/sh
# compile the sound core testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps --top-module tb_sound \
	-f build.f -o Vtb_sound

out=$(./obj_dir/Vtb_sound)
echo "$out"

if echo "$out" | grep -qxF '** PASS **'; then
	exit 0
fi
echo "simulation did not pass"
exit 1
